// File: c64_loader_top.f
source/c64_mem_pkg.sv
source/c64_media_pkg.sv
source/load_control.sv
source/crt_header_parser.sv
source/slot_writer.sv
source/tape_reader.sv
source/c64_loader_top.sv
dv/tb_clock_gen.sv
dv/c64_loader_assertions.sv
dv/c64_loader_tb.sv

// File: Bender.yml
package:
  name: c64_loader

sources:
  - source/c64_mem_pkg.sv
  - source/c64_media_pkg.sv
  - source/load_control.sv
  - source/crt_header_parser.sv
  - source/slot_writer.sv
  - source/tape_reader.sv
  - source/c64_loader_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/c64_loader_assertions.sv
      - dv/c64_loader_tb.sv

// File: dv/c64_loader_tb.sv
//======================================================================
// Media loader testbench
// Host stream, slot pattern, sparse SDRAM model, reference and checks
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module c64_loader_tb;
	import c64_mem_pkg::*;
	import c64_media_pkg::*;

	localparam mem_addr_t ERASE_TOP_TB = 25'h00000FF;
	localparam int PRG_LEN     = 32;
	localparam int TAP_LEN     = 40;
	localparam int CHIP0_SIZE  = 20;
	localparam int CHIP1_SIZE  = 37;
	localparam int CRT_LEN     = 64 + 32 + CHIP0_SIZE + CHIP1_SIZE;
	localparam int ERASE_WORDS = 256 + 65792;
	localparam int WORST_SLOT  = 7;
	localparam longint TOTAL_UNITS = PRG_LEN + 2 * TAP_LEN + 1 + CRT_LEN + ERASE_WORDS;
	localparam longint TIMEOUT_CYCLES = TOTAL_UNITS * WORST_SLOT * 4;

	logic       clk_sys;
	logic       reset_n;
	ioctl_t     ioctl;
	logic       ioctl_wait;
	logic       bus_slot;
	logic       slot_prev;
	logic [7:0] mem_rdata;
	logic       erase_start;
	logic       detach;
	logic       tap_play_btn;
	logic       tap_full;
	logic       tap_empty;
	logic       cass_motor;
	mem_req_t   mem_req;
	cart_info_t cart_info;
	cart_bank_t cart_bank;
	logic       cart_bank_wr;
	logic       cart_attached;
	logic       erasing;
	logic       tap_wr;
	logic [7:0] tap_data;
	logic       tap_play;
	logic       tap_restart;

	integer     seed = 61;
	logic [7:0] mem [int];
	logic [7:0] file_q [$];
	mem_addr_t  exp_waddr [$];
	logic [7:0] exp_wdata [$];
	logic [7:0] exp_fifo [$];
	cart_bank_t exp_bank [$];
	cart_info_t exp_info;
	logic       check_writes;
	logic       playing;
	logic       no_read_check;

	tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(10)) u_clock_gen (
		.clk_sys (clk_sys),
		.reset_n (reset_n)
	);

	c64_loader_top #(
		.ERASE_PACE_LOG2 (2),
		.ERASE_TOP       (ERASE_TOP_TB)
	) u_dut (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.ioctl_i         (ioctl),
		.ioctl_wait_o    (ioctl_wait),
		.bus_slot_i      (bus_slot),
		.mem_rdata_i     (mem_rdata),
		.erase_start_i   (erase_start),
		.detach_i        (detach),
		.tap_play_btn_i  (tap_play_btn),
		.tap_full_i      (tap_full),
		.tap_empty_i     (tap_empty),
		.cass_motor_i    (cass_motor),
		.mem_req_o       (mem_req),
		.cart_info_o     (cart_info),
		.cart_bank_o     (cart_bank),
		.cart_bank_wr_o  (cart_bank_wr),
		.cart_attached_o (cart_attached),
		.erasing_o       (erasing),
		.tap_wr_o        (tap_wr),
		.tap_data_o      (tap_data),
		.tap_play_o      (tap_play),
		.tap_restart_o   (tap_restart)
	);

	//==================================================================
	// Helpers
	//==================================================================
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp)
			report_failure($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// Untouched memory depends on every address bit
	function automatic logic [7:0] fill_byte(input mem_addr_t a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]};
	endfunction

	function automatic logic [7:0] read_mem(input mem_addr_t a);
		if (mem.exists(int'(a)))
			return mem[int'(a)];
		return fill_byte(a);
	endfunction

	// Expected writes, records and FIFO bytes of the file in file_q
	function automatic void build_expected(input media_e kind);
		int         pos;
		int         len;
		int         j;
		mem_addr_t  addr;
		cart_bank_t bank;
		case (kind)
			PRG: begin
				addr = {9'd0, file_q[1], file_q[0]};
				for (j = 2; j < file_q.size(); j++) begin
					exp_waddr.push_back(addr + mem_addr_t'(j - 2));
					exp_wdata.push_back(file_q[j]);
				end
			end
			TAP: begin
				for (j = 0; j < file_q.size(); j++) begin
					exp_waddr.push_back(TAP_BASE + mem_addr_t'(j));
					exp_wdata.push_back(file_q[j]);
					exp_fifo.push_back(file_q[j]);
				end
				// Playback runs one byte past the image
				exp_fifo.push_back(fill_byte(TAP_BASE + mem_addr_t'(file_q.size())));
			end
			CRT: begin
				exp_info = {file_q[8'h16], file_q[8'h17], file_q[8'h18], file_q[8'h19]};
				pos  = 'h40;
				addr = CRT_BASE;
				while (pos < file_q.size()) begin
					len  = {file_q[pos+4], file_q[pos+5], file_q[pos+6], file_q[pos+7]};
					addr = (addr + 25'h1FFF) & ~25'h1FFF;
					bank.bank_type = file_q[pos+9];
					bank.num       = {file_q[pos+10], file_q[pos+11]};
					bank.laddr     = {file_q[pos+12], file_q[pos+13]};
					bank.size      = {file_q[pos+14], file_q[pos+15]};
					bank.raddr     = addr;
					exp_bank.push_back(bank);
					for (j = 0; j < len - 16; j++) begin
						exp_waddr.push_back(addr + mem_addr_t'(j));
						exp_wdata.push_back(file_q[pos+16+j]);
					end
					addr = addr + mem_addr_t'(len - 16);
					pos  = pos + len;
				end
			end
			default: ;
		endcase
	endfunction

	function automatic void add_chip(input int size, input int num);
		int j;
		int len;
		len = size + 16;
		file_q.push_back("C");
		file_q.push_back("H");
		file_q.push_back("I");
		file_q.push_back("P");
		for (j = 3; j >= 0; j--)
			file_q.push_back(8'(len >> (8 * j)));
		file_q.push_back(8'h00);
		file_q.push_back(8'(num + 1));
		file_q.push_back(8'h00);
		file_q.push_back(8'(num));
		file_q.push_back(8'h80);
		file_q.push_back(8'h00);
		file_q.push_back(8'(size >> 8));
		file_q.push_back(8'(size));
		for (j = 0; j < size; j++)
			file_q.push_back(8'($random(seed)));
	endfunction

	//==================================================================
	// Host stream
	//==================================================================
	task automatic host_byte(input int addr, input logic [7:0] data);
		while (ioctl_wait)
			@(posedge clk_sys);
		ioctl.addr <= 25'(addr);
		ioctl.data <= data;
		ioctl.wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl.wr   <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic load_file(input logic [7:0] index);
		int i;
		ioctl.index    <= index;
		ioctl.download <= 1'b1;
		repeat (2) @(posedge clk_sys);
		for (i = 0; i < file_q.size(); i++)
			host_byte(i, file_q[i]);
		while (ioctl_wait)
			@(posedge clk_sys);
		repeat (2) @(posedge clk_sys);
		ioctl.download <= 1'b0;
		repeat (3) @(posedge clk_sys);
		compare_value("writes left after load", exp_waddr.size(), 0);
	endtask

	task automatic run_erase(input mem_addr_t last);
		int a;
		erase_start <= 1'b1;
		@(posedge clk_sys);
		erase_start <= 1'b0;
		repeat (2) @(posedge clk_sys);
		while (erasing)
			@(posedge clk_sys);
		for (a = 0; a <= int'(last); a++) begin
			if (!mem.exists(a))
				report_failure($sformatf("Erase never wrote address 0x%0h", a));
			compare_value("erased byte", mem[a], {8{a[ERASE_PAGE_BIT]}});
		end
		if (mem.exists(int'(last) + 1))
			report_failure("Erase wrote past its last address");
	endtask

	//==================================================================
	// Slot pattern, memory model and monitors
	//==================================================================
	initial begin
		bus_slot = 1'b0;
		forever begin
			bus_slot <= 1'b0;
			repeat (1 + {$random(seed)} % 3) @(posedge clk_sys);
			bus_slot <= 1'b1;
			repeat (2 + {$random(seed)} % 3) @(posedge clk_sys);
		end
	end

	always_comb mem_rdata = read_mem(mem_req.addr);

	always @(posedge clk_sys) begin
		slot_prev <= bus_slot;
		tap_full  <= playing && ({$random(seed)} % 3 == 0);
		if (reset_n && slot_prev && bus_slot && mem_req.ce && mem_req.we) begin
			mem[int'(mem_req.addr)] = mem_req.data;
			if (check_writes) begin
				if (exp_waddr.size() == 0)
					report_failure("Unexpected memory write during a load");
				compare_value("mem_req_o.addr", mem_req.addr, exp_waddr.pop_front());
				compare_value("mem_req_o.data", mem_req.data, exp_wdata.pop_front());
			end
		end
		// A full FIFO at the slot fall must leave the slot unused
		if (no_read_check)
			compare_value("mem_req_o.ce with tap_full_i", mem_req.ce, 1'b0);
		no_read_check <= reset_n && slot_prev && !bus_slot && tap_full && !ioctl_wait;
		if (tap_wr) begin
			if (exp_fifo.size() == 0)
				report_failure("Tape FIFO written after the image ended");
			compare_value("tap_data_o", tap_data, exp_fifo.pop_front());
		end
		if (cart_bank_wr) begin
			if (exp_bank.size() == 0)
				report_failure("Bank record strobed with none expected");
			compare_value("cart_bank_o", cart_bank, exp_bank.pop_front());
		end
	end

	// Slot protocol assertion failures
	always @(posedge clk_sys) begin
		if (u_dut.u_slot_writer.u_slot_assertions.error_count != 0)
			report_failure("A slot protocol assertion failed");
	end

	initial begin
		#(TIMEOUT_CYCLES * 20);
		report_failure("Timeout, the DUT stopped making progress");
	end

	//==================================================================
	// Test sequence
	//==================================================================
	initial begin
		int i;
		ioctl         = '0;
		erase_start   = 1'b0;
		detach        = 1'b0;
		tap_play_btn  = 1'b0;
		tap_full      = 1'b0;
		tap_empty     = 1'b0;
		cass_motor    = 1'b0;
		slot_prev     = 1'b0;
		no_read_check = 1'b0;
		check_writes  = 1'b0;
		playing       = 1'b0;
		@(posedge clk_sys);
		while (!reset_n)
			@(posedge clk_sys);
		@(posedge clk_sys);
		compare_value("mem_req_o.ce after reset", mem_req.ce, 1'b0);
		compare_value("erasing_o after reset", erasing, 1'b0);
		compare_value("tap_play_o after reset", tap_play, 1'b0);
		compare_value("cart_attached_o after reset", cart_attached, 1'b0);

		// Program file at 0x0801
		file_q.delete();
		file_q.push_back(8'h01);
		file_q.push_back(8'h08);
		for (i = 2; i < PRG_LEN; i++)
			file_q.push_back(8'($random(seed)));
		build_expected(PRG);
		check_writes = 1'b1;
		load_file(IDX_PRG);

		check_writes = 1'b0;
		run_erase(ERASE_TOP_TB);

		// Tape image and playback
		file_q.delete();
		for (i = 0; i < TAP_LEN; i++)
			file_q.push_back(8'($random(seed)));
		build_expected(TAP);
		check_writes = 1'b1;
		load_file(IDX_TAP);
		compare_value("tap_play_o after tape load", tap_play, 1'b1);
		compare_value("tap_restart_o after tape load", tap_restart, 1'b0);
		playing <= 1'b1;
		while (exp_fifo.size() != 0)
			@(posedge clk_sys);
		playing <= 1'b0;
		repeat (20) @(posedge clk_sys);

		// Play button and end of tape
		tap_play_btn <= 1'b1;
		repeat (3) @(posedge clk_sys);
		compare_value("tap_play_o after button", tap_play, 1'b0);
		tap_play_btn <= 1'b0;
		repeat (2) @(posedge clk_sys);
		tap_play_btn <= 1'b1;
		repeat (3) @(posedge clk_sys);
		compare_value("tap_play_o after second button", tap_play, 1'b1);
		tap_play_btn <= 1'b0;
		tap_empty    <= 1'b1;
		repeat (3) @(posedge clk_sys);
		compare_value("tap_play_o after empty", tap_play, 1'b0);
		tap_empty <= 1'b0;

		// Motor running within 80 bytes of the end rewinds the tape
		cass_motor <= 1'b1;
		@(posedge clk_sys);
		compare_value("tap_restart_o with motor near end", tap_restart, 1'b1);
		cass_motor <= 1'b0;
		@(posedge clk_sys);
		compare_value("tap_restart_o after motor stop", tap_restart, 1'b0);

		// Cartridge with two chip packets
		file_q.delete();
		for (i = 0; i < 64; i++)
			file_q.push_back(8'($random(seed)));
		add_chip(CHIP0_SIZE, 0);
		add_chip(CHIP1_SIZE, 1);
		build_expected(CRT);
		load_file(IDX_CRT);
		check_writes = 1'b0;
		compare_value("cart_info_o", cart_info, exp_info);
		compare_value("bank records left", exp_bank.size(), 0);
		compare_value("cart_attached_o after load", cart_attached, 1'b1);
		detach <= 1'b1;
		repeat (2) @(posedge clk_sys);
		detach <= 1'b0;
		repeat (2) @(posedge clk_sys);
		compare_value("cart_attached_o after detach", cart_attached, 1'b0);

		run_erase(ERASE_TOP_TB | 25'h0010000);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/c64_loader_assertions.sv
//======================================================================
// Slot and request protocol assertions, bound to the slot writer
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module c64_loader_assertions (
	input wire                         clk_sys,
	input wire                         reset_n,
	input wire                         bus_slot_i,
	input wire c64_mem_pkg::mem_req_t  mem_req_o,
	input wire                         wr_taken_o,
	input wire                         rd_done_o
);
	import c64_mem_pkg::*;

	// Number of failed assertions
	int unsigned error_count = 0;

	// A write is always part of an active request
	we_needs_ce: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_req_o.we |-> mem_req_o.ce)
		else begin
			$error("we high without ce");
			error_count++;
		end

	// Two high slot cycles complete the request
	ce_ends_in_slot: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(mem_req_o.ce && bus_slot_i && $past(bus_slot_i)) |=> !mem_req_o.ce)
		else begin
			$error("ce still high after the perform edge");
			error_count++;
		end

	// No request survives into the next slot fall
	ce_not_across_fall: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(!bus_slot_i && $past(bus_slot_i)) |-> !mem_req_o.ce)
		else begin
			$error("ce high across a slot fall");
			error_count++;
		end

	taken_done_exclusive: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!(wr_taken_o && rd_done_o))
		else begin
			$error("wr_taken and rd_done high together");
			error_count++;
		end

endmodule

bind slot_writer c64_loader_assertions u_slot_assertions (
	.clk_sys    (clk_sys),
	.reset_n    (reset_n),
	.bus_slot_i (bus_slot_i),
	.mem_req_o  (mem_req_o),
	.wr_taken_o (wr_taken_o),
	.rd_done_o  (rd_done_o)
);

`default_nettype wire

// File: dv/tb_clock_gen.sv
//======================================================================
// Testbench clock and reset source
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int unsigned PERIOD_NS    = 20,
	parameter int unsigned RESET_CYCLES = 10
) (
	output logic clk_sys,
	output logic reset_n
);
	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Reset released on a rising edge after the hold time
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: source/c64_loader_top.sv
//======================================================================
// Media loader top level
// Control path plus cartridge parser, slot writer and tape reader
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module c64_loader_top #(
	parameter int unsigned            ERASE_PACE_LOG2 = 5,
	parameter c64_mem_pkg::mem_addr_t ERASE_TOP       = 25'h000FFFF
) (
	input  wire                            clk_sys,
	input  wire                            reset_n,
	input  wire c64_media_pkg::ioctl_t     ioctl_i,
	output logic                           ioctl_wait_o,
	input  wire                            bus_slot_i,
	input  wire [7:0]                      mem_rdata_i,
	input  wire                            erase_start_i,
	input  wire                            detach_i,
	input  wire                            tap_play_btn_i,
	input  wire                            tap_full_i,
	input  wire                            tap_empty_i,
	input  wire                            cass_motor_i,
	output c64_mem_pkg::mem_req_t          mem_req_o,
	output c64_media_pkg::cart_info_t      cart_info_o,
	output c64_media_pkg::cart_bank_t      cart_bank_o,
	output logic                           cart_bank_wr_o,
	output logic                           cart_attached_o,
	output logic                           erasing_o,
	output logic                           tap_wr_o,
	output logic [7:0]                     tap_data_o,
	output logic                           tap_play_o,
	output logic                           tap_restart_o
);
	import c64_mem_pkg::*;
	import c64_media_pkg::*;

	wr_req_t    wr_req;
	logic       wr_taken;
	media_e     media;
	logic       crt_byte;
	logic       crt_payload;
	logic       crt_align;
	logic       rd_req;
	mem_addr_t  rd_addr;
	logic       rd_done;
	logic [7:0] rd_data;

	load_control #(
		.ERASE_PACE_LOG2 (ERASE_PACE_LOG2),
		.ERASE_TOP       (ERASE_TOP)
	) u_load_control (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.ioctl_i         (ioctl_i),
		.erase_start_i   (erase_start_i),
		.detach_i        (detach_i),
		.crt_payload_i   (crt_payload),
		.crt_align_i     (crt_align),
		.wr_taken_i      (wr_taken),
		.media_o         (media),
		.crt_byte_o      (crt_byte),
		.wr_req_o        (wr_req),
		.ioctl_wait_o    (ioctl_wait_o),
		.erasing_o       (erasing_o),
		.cart_attached_o (cart_attached_o)
	);

	// Bank raddr is the load address after alignment
	crt_header_parser u_crt_header_parser (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.ioctl_i        (ioctl_i),
		.crt_byte_i     (crt_byte),
		.load_addr_i    (wr_req.addr),
		.crt_payload_o  (crt_payload),
		.crt_align_o    (crt_align),
		.cart_info_o    (cart_info_o),
		.cart_bank_o    (cart_bank_o),
		.cart_bank_wr_o (cart_bank_wr_o)
	);

	slot_writer u_slot_writer (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.bus_slot_i  (bus_slot_i),
		.wr_req_i    (wr_req),
		.rd_req_i    (rd_req),
		.rd_addr_i   (rd_addr),
		.mem_rdata_i (mem_rdata_i),
		.mem_req_o   (mem_req_o),
		.wr_taken_o  (wr_taken),
		.rd_done_o   (rd_done),
		.rd_data_o   (rd_data)
	);

	tape_reader u_tape_reader (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.ioctl_i        (ioctl_i),
		.media_i        (media),
		.tap_play_btn_i (tap_play_btn_i),
		.tap_full_i     (tap_full_i),
		.tap_empty_i    (tap_empty_i),
		.cass_motor_i   (cass_motor_i),
		.rd_done_i      (rd_done),
		.rd_data_i      (rd_data),
		.rd_req_o       (rd_req),
		.rd_addr_o      (rd_addr),
		.tap_wr_o       (tap_wr_o),
		.tap_data_o     (tap_data_o),
		.tap_play_o     (tap_play_o),
		.tap_restart_o  (tap_restart_o)
	);

endmodule

`default_nettype wire

// File: source/tape_reader.sv
//======================================================================
// Tape playback reader
// Tape extent, play state and feeding of the external tape FIFO
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module tape_reader (
	input  wire                          clk_sys,
	input  wire                          reset_n,
	input  wire c64_media_pkg::ioctl_t   ioctl_i,
	input  wire c64_media_pkg::media_e   media_i,
	input  wire                          tap_play_btn_i,
	input  wire                          tap_full_i,
	input  wire                          tap_empty_i,
	input  wire                          cass_motor_i,
	input  wire                          rd_done_i,
	input  wire [7:0]                    rd_data_i,
	output logic                         rd_req_o,
	output c64_mem_pkg::mem_addr_t       rd_addr_o,
	output logic                         tap_wr_o,
	output logic [7:0]                   tap_data_o,
	output logic                         tap_play_o,
	output logic                         tap_restart_o
);
	import c64_mem_pkg::*;
	import c64_media_pkg::*;

	mem_addr_t play_addr;
	mem_addr_t last_addr;
	logic      tape_download;
	logic      tap_loaded;
	logic      near_end;
	logic      tap_reset;
	logic      btn_d;
	logic      empty_d;

	assign tape_download = ioctl_i.download & (media_i == TAP);
	assign tap_loaded    = play_addr < last_addr;
	assign near_end      = (last_addr - play_addr) < 25'd80;
	// Motor running close to the end rewinds and unloads
	assign tap_reset     = tape_download | (cass_motor_i & near_end);
	assign tap_restart_o = tap_reset;
	assign rd_req_o      = tap_loaded & ~tap_full_i & ~tap_reset;
	assign rd_addr_o     = TAP_BASE + play_addr;
	assign tap_data_o    = rd_data_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			play_addr  <= '0;
			last_addr  <= '0;
			tap_play_o <= 1'b0;
			tap_wr_o   <= 1'b0;
			btn_d      <= 1'b0;
			empty_d    <= 1'b0;
		end else begin
			btn_d    <= tap_play_btn_i;
			empty_d  <= tap_empty_i;
			tap_wr_o <= 1'b0;
			if (tap_reset) begin
				// One extra byte for the decoder's early FIFO check
				last_addr  <= tape_download ? ioctl_i.addr + 25'd2 : 25'd0;
				play_addr  <= '0;
				tap_play_o <= tape_download;
			end else begin
				if (tap_play_btn_i && !btn_d)
					tap_play_o <= ~tap_play_o;
				if (tap_empty_i && !empty_d)
					tap_play_o <= 1'b0;
				if (rd_done_i) begin
					play_addr <= play_addr + 1'b1;
					tap_wr_o  <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/slot_writer.sv
//======================================================================
// Bus slot requester
// Issues pending writes or tape reads inside the granted memory slot
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module slot_writer (
	input  wire                          clk_sys,
	input  wire                          reset_n,
	input  wire                          bus_slot_i,
	input  wire c64_mem_pkg::wr_req_t    wr_req_i,
	input  wire                          rd_req_i,
	input  wire c64_mem_pkg::mem_addr_t  rd_addr_i,
	input  wire [7:0]                    mem_rdata_i,
	output c64_mem_pkg::mem_req_t        mem_req_o,
	output logic                         wr_taken_o,
	output logic                         rd_done_o,
	output logic [7:0]                   rd_data_o
);
	logic        slot_d;
	logic        slot_fall;
	logic        perform;
	logic        ce_q;
	logic        we_q;
	logic [24:0] addr_q;
	logic [7:0]  data_q;

	assign slot_fall = slot_d & ~bus_slot_i;
	// Slot high for two cycles in a row completes the access
	assign perform    = slot_d & bus_slot_i & ce_q;
	assign wr_taken_o = perform & we_q;
	assign rd_done_o  = perform & ~we_q;
	assign mem_req_o  = {ce_q, we_q, addr_q, data_q};

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_d <= 1'b0;
			ce_q   <= 1'b0;
			we_q   <= 1'b0;
		end else begin
			slot_d <= bus_slot_i;
			if (perform) begin
				ce_q <= 1'b0;
				we_q <= 1'b0;
			end else if (slot_fall) begin
				// Writes win over tape reads
				ce_q <= wr_req_i.pending | rd_req_i;
				we_q <= wr_req_i.pending;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (slot_fall) begin
			addr_q <= wr_req_i.pending ? wr_req_i.addr : rd_addr_i;
			data_q <= wr_req_i.data;
		end
		if (rd_done_o)
			rd_data_o <= mem_rdata_i;
	end

endmodule

`default_nettype wire

// File: source/crt_header_parser.sv
//======================================================================
// Cartridge header parser
// File header fields, chip packet records, alignment and payload flags
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module crt_header_parser (
	input  wire                          clk_sys,
	input  wire                          reset_n,
	input  wire c64_media_pkg::ioctl_t   ioctl_i,
	input  wire                          crt_byte_i,
	input  wire c64_mem_pkg::mem_addr_t  load_addr_i,
	output logic                         crt_payload_o,
	output logic                         crt_align_o,
	output c64_media_pkg::cart_info_t    cart_info_o,
	output c64_media_pkg::cart_bank_t    cart_bank_o,
	output logic                         cart_bank_wr_o
);
	import c64_media_pkg::*;

	logic [3:0]  hdr_cnt;
	logic [31:0] blk_len;
	logic        in_chips;
	logic        chip_idle;

	assign in_chips  = crt_byte_i && (ioctl_i.addr >= CRT_CHIPS_OFS);
	assign chip_idle = (hdr_cnt == 4'd0) && (blk_len == 32'd0);

	// First byte of a chip packet, else data while length remains
	assign crt_align_o   = in_chips & chip_idle;
	assign crt_payload_o = in_chips & (hdr_cnt == 4'd0) & (blk_len != 32'd0);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_cnt        <= '0;
			blk_len        <= '0;
			cart_bank_wr_o <= 1'b0;
		end else begin
			cart_bank_wr_o <= 1'b0;
			if (crt_byte_i && ioctl_i.addr == 25'd0) begin
				hdr_cnt <= '0;
				blk_len <= '0;
			end else if (in_chips) begin
				if (chip_idle) begin
					hdr_cnt <= 4'd1;
				end else if (hdr_cnt != 4'd0) begin
					// Wraps back to zero after the last header byte
					hdr_cnt <= hdr_cnt + 1'b1;
					case (hdr_cnt)
						4'd4:  blk_len[31:24] <= ioctl_i.data;
						4'd5:  blk_len[23:16] <= ioctl_i.data;
						4'd6:  blk_len[15:8]  <= ioctl_i.data;
						4'd7:  blk_len[7:0]   <= ioctl_i.data;
						4'd8:  blk_len        <= blk_len - 32'h10;
						4'd15: cart_bank_wr_o <= 1'b1;
						default: ;
					endcase
				end else begin
					blk_len <= blk_len - 1'b1;
				end
			end
		end
	end

	//==================================================================
	// Record fields
	//==================================================================
	always_ff @(posedge clk_sys) begin
		if (crt_byte_i) begin
			case (ioctl_i.addr)
				CRT_ID_OFS:          cart_info_o.id[15:8] <= ioctl_i.data;
				CRT_ID_OFS + 25'd1:  cart_info_o.id[7:0]  <= ioctl_i.data;
				CRT_EXROM_OFS:       cart_info_o.exrom    <= ioctl_i.data;
				CRT_GAME_OFS:        cart_info_o.game     <= ioctl_i.data;
				default: ;
			endcase
		end
		if (in_chips && hdr_cnt != 4'd0) begin
			case (hdr_cnt)
				4'd9:  cart_bank_o.bank_type   <= ioctl_i.data;
				4'd10: cart_bank_o.num[15:8]   <= ioctl_i.data;
				4'd11: cart_bank_o.num[7:0]    <= ioctl_i.data;
				4'd12: cart_bank_o.laddr[15:8] <= ioctl_i.data;
				4'd13: cart_bank_o.laddr[7:0]  <= ioctl_i.data;
				4'd14: cart_bank_o.size[15:8]  <= ioctl_i.data;
				4'd15: begin
					cart_bank_o.size[7:0] <= ioctl_i.data;
					cart_bank_o.raddr     <= load_addr_i;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/load_control.sv
//======================================================================
// Loader control path
// Media decode, load address, pending write, erase and cart attach
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module load_control #(
	parameter int unsigned            ERASE_PACE_LOG2 = 5,
	parameter c64_mem_pkg::mem_addr_t ERASE_TOP       = 25'h000FFFF
) (
	input  wire                         clk_sys,
	input  wire                         reset_n,
	input  wire c64_media_pkg::ioctl_t  ioctl_i,
	input  wire                         erase_start_i,
	input  wire                         detach_i,
	input  wire                         crt_payload_i,
	input  wire                         crt_align_i,
	input  wire                         wr_taken_i,
	output c64_media_pkg::media_e       media_o,
	output logic                        crt_byte_o,
	output c64_mem_pkg::wr_req_t        wr_req_o,
	output logic                        ioctl_wait_o,
	output logic                        erasing_o,
	output logic                        cart_attached_o
);
	import c64_mem_pkg::*;
	import c64_media_pkg::*;

	mem_addr_t                  load_addr;
	mem_addr_t                  erase_last;
	logic [7:0]                 wr_data;
	logic                       pending;
	logic                       host_wr;
	logic                       erase_cram;
	logic                       old_download;
	logic                       old_detach;
	logic [ERASE_PACE_LOG2-1:0] erase_pace;

	always_comb begin
		case (ioctl_i.index)
			IDX_PRG:     media_o = PRG;
			IDX_CRT,
			IDX_CRT_ALT: media_o = CRT;
			IDX_TAP:     media_o = TAP;
			default:     media_o = NONE;
		endcase
	end

	// Host bytes are ignored while the erase owns the address
	assign host_wr      = ioctl_i.wr & ~erasing_o;
	assign crt_byte_o   = host_wr & (media_o == CRT);
	assign ioctl_wait_o = pending;
	assign wr_req_o     = {pending, load_addr, wr_data};

	// Cartridge RAM area is wiped too after a cartridge load
	assign erase_last = erase_cram ? (ERASE_TOP | 25'h0010000) : ERASE_TOP;

	always_ff @(posedge clk_sys) begin
		if (erasing_o)
			wr_data <= {8{load_addr[ERASE_PAGE_BIT]}};
		else if (host_wr)
			wr_data <= ioctl_i.data;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			load_addr       <= '0;
			pending         <= 1'b0;
			erasing_o       <= 1'b0;
			erase_cram      <= 1'b0;
			erase_pace      <= '0;
			old_download    <= 1'b0;
			old_detach      <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			old_download <= ioctl_i.download;
			old_detach   <= detach_i;

			if (wr_taken_i) begin
				pending   <= 1'b0;
				load_addr <= load_addr + 1'b1;
			end

			if (host_wr) begin
				case (media_o)
					PRG: begin
						// Little-endian load address in the first two bytes
						if (ioctl_i.addr == 25'd0)
							load_addr <= {17'd0, ioctl_i.data};
						else if (ioctl_i.addr == 25'd1)
							load_addr[15:8] <= ioctl_i.data;
						else
							pending <= 1'b1;
					end
					CRT: begin
						if (ioctl_i.addr == 25'd0)
							load_addr <= CRT_BASE;
						else if (crt_align_i && load_addr[12:0] != 13'd0)
							load_addr <= {load_addr[24:13] + 1'b1, 13'd0};
						if (crt_payload_i)
							pending <= 1'b1;
					end
					TAP: begin
						if (ioctl_i.addr == 25'd0)
							load_addr <= TAP_BASE;
						pending <= 1'b1;
					end
					default: ;
				endcase
			end

			//==============================================================
			// Paced erase
			//==============================================================
			if (erase_start_i && !erasing_o) begin
				erasing_o  <= 1'b1;
				erase_pace <= '0;
				load_addr  <= '0;
			end else if (erasing_o && !pending) begin
				erase_pace <= erase_pace + 1'b1;
				if (&erase_pace) begin
					if (load_addr <= erase_last) begin
						pending <= 1'b1;
					end else begin
						erasing_o  <= 1'b0;
						erase_cram <= 1'b0;
					end
				end
			end

			// Attached once a cartridge download ends
			if (old_download != ioctl_i.download && media_o == CRT) begin
				cart_attached_o <= old_download;
				if (old_download)
					erase_cram <= 1'b1;
			end
			if (detach_i && !old_detach)
				cart_attached_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/c64_media_pkg.sv
//======================================================================
// Media-side definitions of the media loader
// Media kinds, host stream record, cartridge records, header offsets
//======================================================================
`default_nettype none

package c64_media_pkg;

	typedef enum logic [1:0] {
		NONE = 2'd0,
		PRG  = 2'd1,
		CRT  = 2'd2,
		TAP  = 2'd3
	} media_e;

	// Host download indices
	localparam logic [7:0] IDX_PRG     = 8'h03;
	localparam logic [7:0] IDX_CRT     = 8'h04;
	localparam logic [7:0] IDX_CRT_ALT = 8'hC0;
	localparam logic [7:0] IDX_TAP     = 8'h05;

	// Byte stream from the host
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  data;
		logic [7:0]  index;
	} ioctl_t;

	// Cartridge file header
	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_info_t;

	// One chip packet of the cartridge
	typedef struct packed {
		logic [7:0]             bank_type;
		logic [15:0]            num;
		logic [15:0]            laddr;
		logic [15:0]            size;
		c64_mem_pkg::mem_addr_t raddr;
	} cart_bank_t;

	// File offsets, id is big-endian
	localparam logic [24:0] CRT_ID_OFS    = 25'h16;
	localparam logic [24:0] CRT_EXROM_OFS = 25'h18;
	localparam logic [24:0] CRT_GAME_OFS  = 25'h19;
	localparam logic [24:0] CRT_CHIPS_OFS = 25'h40;

endpackage

`default_nettype wire

// File: source/c64_mem_pkg.sv
//======================================================================
// Memory-side types of the media loader
// SDRAM byte address, request records and fixed region bases
//======================================================================
`default_nettype none

package c64_mem_pkg;

	// Byte address into SDRAM
	typedef logic [24:0] mem_addr_t;

	// Request presented to SDRAM inside a bus slot
	typedef struct packed {
		logic       ce;
		logic       we;
		mem_addr_t  addr;
		logic [7:0] data;
	} mem_req_t;

	// Write held by the control path until a slot takes it
	typedef struct packed {
		logic       pending;
		mem_addr_t  addr;
		logic [7:0] data;
	} wr_req_t;

	// Fixed load regions
	localparam mem_addr_t CRT_BASE = 25'h0100000;
	localparam mem_addr_t TAP_BASE = 25'h0200000;

	// Erase pattern flips every 64 bytes
	localparam int unsigned ERASE_PAGE_BIT = 6;

endpackage

`default_nettype wire
